// ==== src/load_pkg.sv ====
/*
 * Shared types for the RV32 load path.
 * Sizes cover byte, halfword and word only. There are no store or trap types.
 */

`default_nettype none

package load_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [29:0] word_addr_t;
    typedef logic [3:0]  id_t;
    typedef logic [4:0]  ridx_t;
    typedef logic [1:0]  align_t;

    // 0 byte, 1 halfword, 2 word
    typedef logic [1:0]  size_t;

    // Load as sent by the issue stage
    typedef struct packed {
        xlen_t instr;
        xlen_t rs1;
        id_t   id;
    } load_req_t;

    // Metadata held while the memory read is outstanding
    typedef struct packed {
        id_t    id;
        ridx_t  rd_idx;
        align_t align;
        size_t  size;
        logic   unsigned_flag;
        logic   err;
    } load_meta_t;

    // Register file write-back
    typedef struct packed {
        id_t   id;
        ridx_t rd_idx;
        xlen_t data;
        logic  err;
    } wb_t;

endpackage

`default_nettype wire

// ==== src/load_decoder.sv ====
/*
 * Every input is taken as a load. The opcode is not checked.
 * Funct3 011, 110 and 111 set err. No misaligned trap is raised.
 */

`timescale 1ns/10ps
`default_nettype none

module load_decoder import load_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire load_req_t  in_req,
    input  wire logic       in_valid,
    output word_addr_t      mem_addr,
    output logic            mem_valid,
    output load_meta_t      push_meta,
    output logic            push
);

    logic [2:0] funct3;
    xlen_t      imm;
    xlen_t      eff_addr;
    load_meta_t dec_meta;

    assign funct3   = in_req.instr[14:12];
    // I-type immediate, sign-extended
    assign imm      = {{20{in_req.instr[31]}}, in_req.instr[31:20]};
    assign eff_addr = in_req.rs1 + imm;

    always_comb begin
        dec_meta.id            = in_req.id;
        dec_meta.rd_idx        = in_req.instr[11:7];
        dec_meta.align         = eff_addr[1:0];
        dec_meta.size          = 2'd2;
        dec_meta.unsigned_flag = 1'b0;
        dec_meta.err           = 1'b0;
        case (funct3)
            3'b000: begin
                dec_meta.size = 2'd0;
            end
            3'b001: begin
                dec_meta.size = 2'd1;
            end
            3'b010: begin
                dec_meta.size = 2'd2;
            end
            3'b100: begin
                dec_meta.size          = 2'd0;
                dec_meta.unsigned_flag = 1'b1;
            end
            3'b101: begin
                dec_meta.size          = 2'd1;
                dec_meta.unsigned_flag = 1'b1;
            end
            default: begin
                // Still read memory so the answer keeps its place in order
                dec_meta.err = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
            push      <= 1'b0;
        end else begin
            mem_valid <= in_valid;
            push      <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr  <= eff_addr[31:2];
        push_meta <= dec_meta;
    end

endmodule

`default_nettype wire

// ==== src/load_queue.sv ====
/*
 * No full flag. The issue side credits keep pushes within QUE_SIZE.
 * Pop is assumed only while the head entry is valid.
 */

`timescale 1ns/10ps
`default_nettype none

module load_queue import load_pkg::*; #(
    parameter int QUE_SIZE = 4
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire load_meta_t push_meta,
    input  wire logic       push,
    input  wire logic       pop,
    output load_meta_t      head
);

    load_meta_t [QUE_SIZE-1:0] que_meta;
    logic       [QUE_SIZE-1:0] que_valid;
    load_meta_t [QUE_SIZE-1:0] next_meta;
    logic       [QUE_SIZE-1:0] next_valid;
    logic                      push_done;

    always_comb begin
        next_meta  = que_meta;
        next_valid = que_valid;
        push_done  = 1'b0;

        // Shift toward the head first
        if (pop) begin
            for (int i = 0; i < QUE_SIZE - 1; i++) begin
                next_meta[i]  = next_meta[i+1];
                next_valid[i] = next_valid[i+1];
            end
            next_valid[QUE_SIZE-1] = 1'b0;
        end

        // then fill the lowest free slot, which lands behind the shifted entries
        if (push) begin
            for (int i = 0; i < QUE_SIZE; i++) begin
                if (!next_valid[i] && !push_done) begin
                    next_meta[i]  = push_meta;
                    next_valid[i] = 1'b1;
                    push_done     = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            que_valid <= '0;
        end else begin
            que_valid <= next_valid;
        end
    end

    always_ff @(posedge clk) begin
        que_meta <= next_meta;
    end

    assign head = que_meta[0];

endmodule

`default_nettype wire

// ==== src/load_aligner.sv ====
/*
 * The head entry must belong to the answer on rsp_valid.
 * A halfword uses align bit 1 only, and a word ignores align.
 */

`timescale 1ns/10ps
`default_nettype none

module load_aligner import load_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire load_meta_t head,
    input  wire xlen_t      rsp_data,
    input  wire logic       rsp_valid,
    output wb_t             wb,
    output logic            wb_valid
);

    xlen_t      byte_shift;
    xlen_t      half_shift;
    logic [7:0] sel_byte;
    logic [15:0] sel_half;
    xlen_t      result;

    assign byte_shift = rsp_data >> {head.align, 3'b000};
    assign half_shift = rsp_data >> {head.align[1], 4'b0000};
    assign sel_byte   = byte_shift[7:0];
    assign sel_half   = half_shift[15:0];

    always_comb begin
        case (head.size)
            2'd0: begin
                result = {{24{sel_byte[7] & ~head.unsigned_flag}}, sel_byte};
            end
            2'd1: begin
                result = {{16{sel_half[15] & ~head.unsigned_flag}}, sel_half};
            end
            default: begin
                result = rsp_data;
            end
        endcase
        // Unsupported funct3 returns zero
        if (head.err) begin
            result = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= rsp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            wb.id     <= head.id;
            wb.rd_idx <= head.rd_idx;
            wb.data   <= result;
            wb.err    <= head.err;
        end
    end

endmodule

`default_nettype wire

// ==== src/load_unit.sv ====
/*
 * Upstream starts with QUE_SIZE credits and must not exceed them.
 * Memory answers in order, and the write-back side never stalls.
 */

`timescale 1ns/10ps
`default_nettype none

module load_unit import load_pkg::*; #(
    parameter int QUE_SIZE = 4
) (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire load_req_t in_req,
    input  wire logic      in_valid,
    output logic           in_credit,
    output word_addr_t     mem_addr,
    output logic           mem_valid,
    input  wire xlen_t     mem_rdata,
    input  wire logic      mem_rvalid,
    output wb_t            wb,
    output logic           wb_valid
);

    load_meta_t push_meta;
    logic       push;
    load_meta_t head;

    load_decoder i_load_decoder (
        .clk       (clk),
        .reset     (reset),
        .in_req    (in_req),
        .in_valid  (in_valid),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .push_meta (push_meta),
        .push      (push)
    );

    // Each memory answer retires the head entry
    load_queue #(
        .QUE_SIZE (QUE_SIZE)
    ) i_load_queue (
        .clk       (clk),
        .reset     (reset),
        .push_meta (push_meta),
        .push      (push),
        .pop       (mem_rvalid),
        .head      (head)
    );

    load_aligner i_load_aligner (
        .clk       (clk),
        .reset     (reset),
        .head      (head),
        .rsp_data  (mem_rdata),
        .rsp_valid (mem_rvalid),
        .wb        (wb),
        .wb_valid  (wb_valid)
    );

    // One write-back frees one queue slot
    assign in_credit = wb_valid;

endmodule

`default_nettype wire

// ==== tb/mem_model.sv ====
/*
 * Data memory model. The word at word address A is A * 32'h9e37_79b9 + 32'h1357_2468.
 * Answers keep request order, at most one per cycle, 1 to 6 cycles after the request.
 */

`timescale 1ns/10ps
`default_nettype none

module mem_model import load_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire word_addr_t mem_addr,
    input  wire logic       mem_valid,
    output xlen_t           mem_rdata,
    output logic            mem_rvalid
);

    word_addr_t addr_q [$];
    int         due_q [$];
    int         cycle;
    int         due;
    logic       ready;
    word_addr_t addr;
    xlen_t      rdata;

    initial begin
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        cycle      = 0;
        forever begin
            @(posedge clk);
            ready = 1'b0;
            rdata = '0;
            if (reset) begin
                addr_q.delete();
                due_q.delete();
            end else begin
                if (mem_valid) begin
                    // Due on the capture cycle means the answer is seen at the next edge
                    due = cycle + int'($urandom_range(5, 0));
                    if (due_q.size() > 0 && due <= due_q[$]) begin
                        due = due_q[$] + 1;
                    end
                    addr_q.push_back(mem_addr);
                    due_q.push_back(due);
                end
                if (due_q.size() > 0 && due_q[0] <= cycle) begin
                    addr  = addr_q.pop_front();
                    ready = 1'b1;
                    rdata = {2'b00, addr} * 32'h9e37_79b9 + 32'h1357_2468;
                    void'(due_q.pop_front());
                end
            end
            #1;
            mem_rvalid = ready;
            mem_rdata  = rdata;
            cycle++;
        end
    end

endmodule

`default_nettype wire

// ==== tb/load_unit_tb.sv ====
/*
 * Self-checking testbench for load_unit with QUE_SIZE 4.
 * Directed rows cover funct3 0 to 7 at byte offsets 0 to 3, the rest are random.
 * Expected write-backs follow the memory rule of mem_model.
 */

`timescale 1ns/10ps
`default_nettype none

module load_unit_tb import load_pkg::*; ();

    localparam int QUE_SIZE       = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_DIRECTED   = 32;
    localparam int NUM_ROWS       = NUM_DIRECTED + 32;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 20 + RESET_CYCLES;

    // One load with its expected write-back and credit pulse
    typedef struct packed {
        load_req_t req;
        wb_t       exp;
        logic      credit;
    } row_t;

    row_t       stim_table [NUM_ROWS];
    logic       clk;
    logic       reset;
    load_req_t  in_req;
    logic       in_valid;
    logic       in_credit;
    word_addr_t mem_addr;
    logic       mem_valid;
    xlen_t      mem_rdata;
    logic       mem_rvalid;
    wb_t        wb;
    logic       wb_valid;
    int         issued;
    int         returned;
    int         wb_count;
    int         stall_cycles;
    int         row;

    load_unit #(.QUE_SIZE (QUE_SIZE)) i_load_unit (.*);

    mem_model i_mem_model (.*);

    function automatic xlen_t load_instr(logic [11:0] imm, logic [2:0] funct3, ridx_t rd);
        return {imm, 5'd0, funct3, rd, 7'b0000011};
    endfunction

    function automatic wb_t expected_wb(load_req_t req);
        xlen_t       addr;
        xlen_t       word;
        logic [7:0]  b;
        logic [15:0] h;
        wb_t         res;
        addr = req.rs1 + {{20{req.instr[31]}}, req.instr[31:20]};
        word = {2'b00, addr[31:2]} * 32'h9e37_79b9 + 32'h1357_2468;
        b    = 8'(word >> (8 * addr[1:0]));
        h    = addr[1] ? word[31:16] : word[15:0];
        res  = '{id: req.id, rd_idx: req.instr[11:7], data: '0, err: 1'b0};
        case (req.instr[14:12])
            3'b000:  res.data = {{24{b[7]}}, b};
            3'b001:  res.data = {{16{h[15]}}, h};
            3'b010:  res.data = word;
            3'b100:  res.data = {24'd0, b};
            3'b101:  res.data = {16'd0, h};
            default: res.err = 1'b1;
        endcase
        return res;
    endfunction

    task automatic build_table();
        load_req_t   req;
        logic [11:0] imm;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i < NUM_DIRECTED) begin
                // -8 and +36 keep the byte offset of rs1, which steps with i / 8
                imm       = (i % 2 == 0) ? 12'hff8 : 12'h024;
                req.instr = load_instr(imm, 3'(i % 8), ridx_t'(i));
                req.rs1   = 32'h0000_2000 + xlen_t'(i * 64 + i / 8);
                req.id    = id_t'(i);
            end else begin
                req.instr = load_instr(12'($urandom), 3'($urandom), ridx_t'($urandom));
                req.rs1   = $urandom;
                req.id    = id_t'($urandom);
            end
            stim_table[i].req    = req;
            stim_table[i].exp    = expected_wb(req);
            stim_table[i].credit = 1'b1;
        end
    endtask

    task automatic report_mismatch(string name, xlen_t exp, xlen_t act);
        $display("Fail at %0t: %s expected %h, actual %h", $time, name, exp, act);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_wb(wb_t exp, wb_t act);
        if (act.id !== exp.id) begin
            report_mismatch("wb.id", xlen_t'(exp.id), xlen_t'(act.id));
        end
        if (act.rd_idx !== exp.rd_idx) begin
            report_mismatch("wb.rd_idx", xlen_t'(exp.rd_idx), xlen_t'(act.rd_idx));
        end
        if (act.data !== exp.data) begin
            report_mismatch("wb.data", exp.data, act.data);
        end
        if (act.err !== exp.err) begin
            report_mismatch("wb.err", xlen_t'(exp.err), xlen_t'(act.err));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            report_mismatch(name, xlen_t'(exp), xlen_t'(act));
        end
    endtask

    task automatic check_credits(int exp, int act);
        if (act != exp) begin
            report_mismatch("credit count", xlen_t'(exp), xlen_t'(act));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Write-backs arrive in table order, each with one credit pulse
    always @(negedge clk) begin
        if (!reset) begin
            if (wb_valid && wb_count >= NUM_ROWS) begin
                $display("A write-back arrived after every load had been answered");
                $display("Simulation FAILED");
                $fatal(1);
            end else if (wb_valid) begin
                check_flag("in_credit", stim_table[wb_count].credit, in_credit);
                check_wb(stim_table[wb_count].exp, wb);
                wb_count++;
            end
            if (in_credit) begin
                returned++;
            end
        end
    end

    initial begin
        void'($urandom(32'heb45_b0e5));
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_req       = '0;
        issued       = 0;
        returned     = 0;
        wb_count     = 0;
        stall_cycles = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        // Issue back-to-back while a credit is held
        row = 0;
        while (row < NUM_ROWS) begin
            if (QUE_SIZE - issued + returned > 0) begin
                in_req   = stim_table[row].req;
                in_valid = 1'b1;
                issued++;
                row++;
            end else begin
                in_valid = 1'b0;
                stall_cycles++;
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        in_req   = '0;
        wait (wb_count == NUM_ROWS);
        repeat (5) @(posedge clk);
        check_credits(QUE_SIZE, QUE_SIZE - issued + returned);
        if (stall_cycles == 0) begin
            $display("Upstream never ran out of credits, so no stall was exercised");
            $display("Simulation FAILED");
            $fatal(1);
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: write-backs stopped arriving, %0d of %0d received",
                 wb_count, NUM_ROWS);
        $display("Simulation FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== list.f ====
src/load_pkg.sv
src/load_decoder.sv
src/load_queue.sv
src/load_aligner.sv
src/load_unit.sv
tb/mem_model.sv
tb/load_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the load unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module load_unit_tb -f list.f -o Vload_unit_tb; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vload_unit_tb; then
    echo "Simulation returned a failing status"
    exit 1
fi

exit 0
